//--- flist.f
+incdir+.
pos_switch_pkg.sv
pos_route_decode.sv
pos_output_arbiter.sv
pos_switch.sv
pos_switch_assertions.sv
tb_pos_switch.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/100ps
TOP       = tb_pos_switch
DUT_TOP   = pos_switch
FLIST     = flist.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+1000

SOURCES = $(shell grep -v '^+' $(FLIST)) pos_switch_cfg.svh

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "TEST FAILED" $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TEST PASSED" $(LOG) || { echo "Simulation ended without a result"; exit 1; }

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/100ps \
		--top-module $(DUT_TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tb_pos_switch.sv
`timescale 1ns/100ps
`include "pos_switch_cfg.svh"

module tb_pos_switch;

  import pos_switch_pkg::*;

  localparam int N          = `POS_N_PORTS;
  localparam int RUN_CYCLES = 4000;
  localparam int DRAIN_MAX  = 2000;

  logic       aclk;
  logic       rst_n;
  axis_beat_t sink_beat [N];
  port_mask_t sink_tvalid;
  port_mask_t sink_tready;
  axis_beat_t src_beat [N];
  port_mask_t src_tvalid;
  port_mask_t src_tready;
  port_mask_t decode_err;

  logic [31:0] rng_state;

  // Sender state per sink
  int         beats_left [N] = '{default: 0};
  tdest_t     pkt_dest   [N] = '{default: '0};
  logic       pkt_bad    [N] = '{default: 1'b0};
  logic       pkt_first  [N] = '{default: 1'b0};
  port_mask_t sink_xfer;

  // Expected beats, indexed by sink * N + destination
  axis_beat_t exp_q [N*N][$];
  int         err_exp  [N] = '{default: 0};
  int         err_seen [N] = '{default: 0};

  // Output side tracking for packet order and fairness
  logic       out_active  [N] = '{default: 1'b0};
  port_idx_t  out_sink    [N] = '{default: '0};
  port_mask_t out_waited  [N] = '{default: '0};
  port_idx_t  last_sink   [N] = '{default: '0};
  port_mask_t last_waited [N] = '{default: '0};
  logic       held_valid  [N] = '{default: 1'b0};
  axis_beat_t held_beat   [N];

  int mismatch_count = 0;
  int other_count    = 0;

  pos_switch dut (
    .aclk        (aclk),
    .rst_n       (rst_n),
    .sink_beat   (sink_beat),
    .sink_tvalid (sink_tvalid),
    .sink_tready (sink_tready),
    .src_beat    (src_beat),
    .src_tvalid  (src_tvalid),
    .src_tready  (src_tready),
    .decode_err  (decode_err)
  );

  initial begin
    aclk = 1'b0;
    forever #4 aclk = ~aclk;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  task automatic check_beat(input axis_beat_t got, input axis_beat_t exp, input string what);
    if (got !== exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s, got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      mismatch_count++;
      $display("mismatch at %0t: %s, got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic report_error(input string msg);
    other_count++;
    $display("error at %0t: %s", $time, msg);
  endtask

  function automatic axis_beat_t make_beat(input int i);
    axis_beat_t b;
    b.tdata = tdata_t'({next_rand(), next_rand()});
    b.tkeep = tkeep_t'(next_rand());
    b.tlast = (beats_left[i] == 1);
    // Low id bits name the sender
    b.tid   = tid_t'(next_rand());
    b.tid[`POS_IDX_BITS-1:0] = port_idx_t'(i);
    b.tdest = pkt_dest[i];
    return b;
  endfunction

  task automatic start_packet(input int i);
    beats_left[i] = 1 + int'(next_rand() % 4);
    pkt_first[i]  = 1'b1;
    pkt_bad[i]    = ((next_rand() % 8) == 0);
    if (pkt_bad[i]) begin
      pkt_dest[i] = tdest_t'(N + int'(next_rand() % ((1 << `POS_DEST_BITS) - N)));
    end else begin
      pkt_dest[i] = tdest_t'(next_rand() % N);
    end
  endtask

  // Sinks whose first beat for output j is on the wire
  function automatic port_mask_t waiting_mask(input int j);
    port_mask_t m;
    m = '0;
    for (int k = 0; k < N; k++) begin
      m[k] = sink_tvalid[k] && pkt_first[k] && !pkt_bad[k] && (int'(pkt_dest[k]) == j);
    end
    return m;
  endfunction

  task automatic drive_inputs(input bit gen_new);
    for (int i = 0; i < N; i++) begin
      if (sink_xfer[i]) begin
        beats_left[i]--;
        pkt_first[i]   = 1'b0;
        sink_tvalid[i] = 1'b0;
      end
      if (!sink_tvalid[i]) begin
        if (beats_left[i] == 0) begin
          // A sink rests at least one cycle between packets
          if (gen_new && !sink_xfer[i] && (next_rand() % 4) != 0) begin
            start_packet(i);
            sink_beat[i]   = make_beat(i);
            sink_tvalid[i] = 1'b1;
          end
        end else if (!gen_new || (next_rand() % 4) != 0) begin
          sink_beat[i]   = make_beat(i);
          sink_tvalid[i] = 1'b1;
        end
      end
    end
    sink_xfer  = '0;
    src_tready = gen_new ? port_mask_t'(next_rand()) : '1;
  endtask

  task automatic sample_outputs();
    port_mask_t waiting;
    port_idx_t  s;
    int         q;
    for (int i = 0; i < N; i++) begin
      if (sink_tvalid[i] && pkt_bad[i] && !sink_tready[i]) begin
        report_error($sformatf("sink %0d stalled on a beat with a bad destination", i));
      end
      if (decode_err[i]) begin
        err_seen[i]++;
      end
      if (sink_tvalid[i] && sink_tready[i]) begin
        sink_xfer[i] = 1'b1;
        if (!pkt_bad[i]) begin
          exp_q[i*N + int'(pkt_dest[i])].push_back(sink_beat[i]);
        end else if (pkt_first[i]) begin
          err_exp[i]++;
        end
      end
    end
    for (int j = 0; j < N; j++) begin
      waiting = waiting_mask(j);
      if (held_valid[j]) begin
        if (!src_tvalid[j]) begin
          report_error($sformatf("source %0d dropped tvalid on a stalled beat", j));
        end else begin
          check_beat(src_beat[j], held_beat[j], $sformatf("held beat on source %0d", j));
        end
      end
      held_valid[j] = 1'b0;
      if (out_active[j]) begin
        out_waited[j] &= waiting;
      end
      if (src_tvalid[j]) begin
        s = src_beat[j].tid[`POS_IDX_BITS-1:0];
        if (!out_active[j]) begin
          if (s == last_sink[j] && last_waited[j] != '0) begin
            report_error($sformatf("source %0d served sink %0d twice while another waited",
                                   j, s));
          end
          out_active[j] = 1'b1;
          out_sink[j]   = s;
          out_waited[j] = waiting & ~(port_mask_t'(1) << s);
        end else if (s != out_sink[j]) begin
          report_error($sformatf("source %0d mixed a beat of sink %0d into a packet", j, s));
        end
        if (src_tready[j]) begin
          // The path is combinational, so the sink hands over in the same cycle
          if (!(sink_tvalid[s] && sink_tready[s])) begin
            report_error($sformatf("source %0d took a beat that sink %0d did not hand over",
                                   j, s));
          end
          q = int'(s) * N + j;
          if (exp_q[q].size() == 0) begin
            report_error($sformatf("source %0d sent a beat that no sink sent", j));
          end else begin
            check_beat(src_beat[j], exp_q[q].pop_front(), $sformatf("beat on source %0d", j));
          end
          if (src_beat[j].tlast) begin
            out_active[j]  = 1'b0;
            last_sink[j]   = out_sink[j];
            last_waited[j] = out_waited[j];
          end
        end else begin
          held_valid[j] = 1'b1;
          held_beat[j]  = src_beat[j];
        end
      end
    end
  endtask

  // Drive after the falling edge, sample 1 ns before the rising edge
  task automatic step_cycle(input bit gen_new);
    @(negedge aclk);
    drive_inputs(gen_new);
    #3;
    sample_outputs();
  endtask

  function automatic bit all_idle();
    bit idle;
    idle = (sink_tvalid == '0) && (src_tvalid == '0);
    for (int i = 0; i < N; i++) begin
      if (beats_left[i] != 0 || out_active[i]) begin
        idle = 1'b0;
      end
    end
    return idle;
  endfunction

  initial begin
    int cycles;
    int idle_run;
    $timeformat(-9, 0, " ns", 0);
    rng_state   = 32'h4934;
    rst_n       = 1'b0;
    sink_tvalid = '0;
    src_tready  = '0;
    sink_xfer   = '0;
    for (int i = 0; i < N; i++) begin
      sink_beat[i] = '0;
    end
    repeat (3) @(posedge aclk);
    @(negedge aclk);
    rst_n = 1'b1;

    for (cycles = 0; cycles < RUN_CYCLES; cycles++) begin
      step_cycle(1'b1);
    end

    // No new packets, outputs always ready, until everything is quiet
    cycles   = 0;
    idle_run = 0;
    while (idle_run < 3 && cycles < DRAIN_MAX) begin
      step_cycle(1'b0);
      idle_run = all_idle() ? idle_run + 1 : 0;
      cycles++;
    end
    if (idle_run < 3) begin
      report_error("timeout while waiting for the traffic to drain");
    end

    for (int i = 0; i < N; i++) begin
      check_count(err_seen[i], err_exp[i], $sformatf("decode errors of sink %0d", i));
    end
    for (int q = 0; q < N*N; q++) begin
      if (exp_q[q].size() != 0) begin
        report_error($sformatf("%0d beats from sink %0d never left source %0d",
                               exp_q[q].size(), q / N, q % N));
      end
    end
    other_count += int'(dut.u_assert.fail_count);

    $display("Checks done: %0d mismatches, %0d other errors", mismatch_count, other_count);
    if (mismatch_count == 0 && other_count == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

//--- pos_switch_assertions.sv
`timescale 1ns/100ps
`include "pos_switch_cfg.svh"

module pos_switch_assertions (
  input logic                       aclk,
  input logic                       rst_n,
  input pos_switch_pkg::axis_beat_t src_beat [`POS_N_PORTS],
  input pos_switch_pkg::port_mask_t src_tvalid,
  input pos_switch_pkg::port_mask_t src_tready,
  input pos_switch_pkg::port_mask_t sink_accept [`POS_N_PORTS],
  input pos_switch_pkg::port_mask_t decode_err
);

  import pos_switch_pkg::*;

  // Number of failed assertions so far
  int unsigned fail_count = 0;

  for (genvar p = 0; p < `POS_N_PORTS; p++) begin : g_port
    // Stalled source beat holds still
    assert property (@(posedge aclk) disable iff (!rst_n)
      src_tvalid[p] && !src_tready[p] |=> src_tvalid[p] && $stable(src_beat[p]))
    else begin
      fail_count++;
      $error("source %0d changed or dropped a stalled beat", p);
    end

    // A sink beat goes to one output only
    assert property (@(posedge aclk) disable iff (!rst_n)
      $onehot0(sink_accept[p]))
    else begin
      fail_count++;
      $error("sink %0d accepted by more than one output", p);
    end

    // Error flag is a single cycle pulse
    assert property (@(posedge aclk) disable iff (!rst_n)
      decode_err[p] |=> !decode_err[p])
    else begin
      fail_count++;
      $error("decode_err of sink %0d high for more than one cycle", p);
    end
  end

endmodule

bind pos_switch pos_switch_assertions u_assert (
  .aclk        (aclk),
  .rst_n       (rst_n),
  .src_beat    (src_beat),
  .src_tvalid  (src_tvalid),
  .src_tready  (src_tready),
  .sink_accept (sink_accept),
  .decode_err  (decode_err)
);

//--- pos_switch.sv
`timescale 1ns/100ps
`include "pos_switch_cfg.svh"

module pos_switch (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  pos_switch_pkg::axis_beat_t sink_beat [`POS_N_PORTS],
  input  pos_switch_pkg::port_mask_t sink_tvalid,
  output pos_switch_pkg::port_mask_t sink_tready,
  output pos_switch_pkg::axis_beat_t src_beat [`POS_N_PORTS],
  output pos_switch_pkg::port_mask_t src_tvalid,
  input  pos_switch_pkg::port_mask_t src_tready,
  output pos_switch_pkg::port_mask_t decode_err
);

  import pos_switch_pkg::*;

  // Indexed by sink, one bit per output
  port_mask_t sink_req [`POS_N_PORTS];
  // Indexed by output, one bit per sink
  port_mask_t arb_req  [`POS_N_PORTS];

  // Indexed by output, one bit per sink
  port_mask_t arb_accept  [`POS_N_PORTS];
  // Indexed by sink, one bit per output
  port_mask_t sink_accept [`POS_N_PORTS];

  // Transpose requests and accepts between the two ranks
  for (genvar i = 0; i < `POS_N_PORTS; i++) begin : g_xpose
    for (genvar j = 0; j < `POS_N_PORTS; j++) begin : g_bit
      assign arb_req[j][i]     = sink_req[i][j];
      assign sink_accept[i][j] = arb_accept[j][i];
    end
  end

  // Decoder rank, one per sink port
  for (genvar i = 0; i < `POS_N_PORTS; i++) begin : g_dec
    pos_route_decode u_dec (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .beat       (sink_beat[i]),
      .tvalid     (sink_tvalid[i]),
      .tready     (sink_tready[i]),
      .accepted   (sink_accept[i]),
      .req        (sink_req[i]),
      .decode_err (decode_err[i])
    );
  end

  // Arbiter rank, one per source port
  for (genvar j = 0; j < `POS_N_PORTS; j++) begin : g_arb
    pos_output_arbiter u_arb (
      .aclk       (aclk),
      .rst_n      (rst_n),
      .req        (arb_req[j]),
      .sink_beats (sink_beat),
      .accept     (arb_accept[j]),
      .beat       (src_beat[j]),
      .tvalid     (src_tvalid[j]),
      .tready     (src_tready[j])
    );
  end

endmodule

//--- pos_output_arbiter.sv
`timescale 1ns/100ps
`include "pos_switch_cfg.svh"

module pos_output_arbiter (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  pos_switch_pkg::port_mask_t req,
  input  pos_switch_pkg::axis_beat_t sink_beats [`POS_N_PORTS],
  output pos_switch_pkg::port_mask_t accept,
  output pos_switch_pkg::axis_beat_t beat,
  output logic                       tvalid,
  input  logic                       tready
);

  import pos_switch_pkg::*;

  typedef enum logic {
    ARB_IDLE,
    ARB_LOCKED
  } arb_state_t;

  arb_state_t state_q;
  port_idx_t  grant_q;
  // Sink served last, the search starts just after it
  port_idx_t  rr_ptr;

  logic       found;
  port_idx_t  pick;
  port_idx_t  sel;
  logic       xfer;

  // Rotating search for the first requester after the pointer
  always_comb begin
    int idx;
    found = 1'b0;
    pick  = '0;
    for (int k = 1; k <= `POS_N_PORTS; k++) begin
      idx = (int'(rr_ptr) + k) % `POS_N_PORTS;
      if (!found && req[idx]) begin
        found = 1'b1;
        pick  = port_idx_t'(idx);
      end
    end
  end

  // While locked the granted sink owns the port
  assign sel = (state_q == ARB_LOCKED) ? grant_q : pick;

  always_comb begin
    if (state_q == ARB_LOCKED) begin
      tvalid = req[grant_q];
    end else begin
      tvalid = found;
    end
  end

  // Beat goes out unchanged, tdest included
  assign beat = sink_beats[sel];
  assign xfer = tvalid && tready;

  // Tell the chosen sink its beat was taken
  always_comb begin
    accept = '0;
    if (xfer) begin
      accept[sel] = 1'b1;
    end
  end

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ARB_IDLE;
      grant_q <= '0;
      rr_ptr  <= '0;
    end else begin
      case (state_q)
        ARB_IDLE: begin
          if (found) begin
            if (xfer && beat.tlast) begin
              // Single beat packet, done in the same cycle
              rr_ptr <= pick;
            end else begin
              // Lock even when stalled, so the held beat cannot change
              state_q <= ARB_LOCKED;
              grant_q <= pick;
            end
          end
        end
        ARB_LOCKED: begin
          if (xfer && beat.tlast) begin
            state_q <= ARB_IDLE;
            rr_ptr  <= grant_q;
          end
        end
        default: begin
          state_q <= ARB_IDLE;
        end
      endcase
    end
  end

endmodule

//--- pos_route_decode.sv
`timescale 1ns/100ps
`include "pos_switch_cfg.svh"

module pos_route_decode (
  input  logic                       aclk,
  input  logic                       rst_n,
  input  pos_switch_pkg::axis_beat_t beat,
  input  logic                       tvalid,
  output logic                       tready,
  input  pos_switch_pkg::port_mask_t accepted,
  output pos_switch_pkg::port_mask_t req,
  output logic                       decode_err
);

  import pos_switch_pkg::*;

  // Packet state, set on the first beat and cleared after tlast
  logic      in_pkt;
  logic      drop_q;
  port_idx_t dest_q;

  logic      bad_dest;
  logic      dropping;
  logic      xfer;
  port_idx_t cur_dest;

  // Only looked at on the first beat of a packet
  assign bad_dest = (int'(beat.tdest) >= `POS_N_PORTS);

  // First beat routes on its own tdest, later beats on the locked one
  assign cur_dest = in_pkt ? dest_q : port_idx_t'(beat.tdest);

  // Undeliverable packet, either already locked or starting now
  assign dropping = in_pkt ? drop_q : (tvalid && bad_dest);

  // At most one request bit, never for a dropped beat
  always_comb begin
    req = '0;
    if (tvalid && !dropping) begin
      req[cur_dest] = 1'b1;
    end
  end

  // A dropped beat is swallowed right away
  assign tready = dropping || (|accepted);
  assign xfer   = tvalid && tready;

  always_ff @(posedge aclk or negedge rst_n) begin
    if (!rst_n) begin
      in_pkt     <= 1'b0;
      drop_q     <= 1'b0;
      dest_q     <= '0;
      decode_err <= 1'b0;
    end else begin
      // One pulse per bad packet, raised by its first beat
      decode_err <= xfer && !in_pkt && bad_dest;

      if (xfer) begin
        if (!in_pkt) begin
          dest_q <= port_idx_t'(beat.tdest);
          drop_q <= bad_dest;
        end
        in_pkt <= !beat.tlast;
        // Packet done, next beat starts a fresh decode
        if (beat.tlast) begin
          drop_q <= 1'b0;
        end
      end
    end
  end

endmodule

//--- pos_switch_pkg.sv
`include "pos_switch_cfg.svh"

package pos_switch_pkg;

  // Payload of one beat
  typedef logic [`POS_DATA_BITS-1:0] tdata_t;

  // Byte enables for tdata
  typedef logic [`POS_KEEP_BITS-1:0] tkeep_t;

  // Stream id, carried through the switch as is
  typedef logic [`POS_TID_BITS-1:0] tid_t;

  // Destination requested by the sender
  typedef logic [`POS_DEST_BITS-1:0] tdest_t;

  // One bit per port
  typedef logic [`POS_N_PORTS-1:0] port_mask_t;

  // Index of a port
  typedef logic [`POS_IDX_BITS-1:0] port_idx_t;

  // Everything that travels with a beat, handshake kept apart
  typedef struct packed {
    tdata_t tdata;
    tkeep_t tkeep;
    logic   tlast;
    tid_t   tid;
    tdest_t tdest;
  } axis_beat_t;

endpackage

//--- pos_switch_cfg.svh
`ifndef POS_SWITCH_CFG_SVH
`define POS_SWITCH_CFG_SVH

// Sink ports and source ports, numbered 0 .. N-1
`define POS_N_PORTS 4

// Width of one data beat
`define POS_DATA_BITS 64

// One enable bit per data byte
`define POS_KEEP_BITS (`POS_DATA_BITS / 8)

// Id field, passed through untouched
`define POS_TID_BITS 6

// Destination field
// Wider than the port index, so some destinations name no port
`define POS_DEST_BITS 4

// Bits needed to index a port
`define POS_IDX_BITS $clog2(`POS_N_PORTS)

`endif
